// ==== common/aes_block_pkg.sv ====
`default_nettype none

package aes_block_pkg;

        // ========================================================================
        // Stream word and AES block geometry
        // ========================================================================

        // One AXI stream beat
        localparam int WORD_BITS = 32;

        // AES state is four columns of one word each
        localparam int WORDS_PER_BLOCK = 4;

        localparam int BLOCK_BITS = WORD_BITS * WORDS_PER_BLOCK;

        // Width of the word position counter inside a block
        localparam int WORD_IDX_BITS = $clog2(WORDS_PER_BLOCK);

        typedef logic [WORD_BITS-1:0] word_t;

        // First word of a block sits in the top bits
        typedef logic [BLOCK_BITS-1:0] block_t;

        typedef logic [WORD_IDX_BITS-1:0] word_idx_t;

        // Position of the final word of a block
        localparam word_idx_t LAST_WORD_IDX = word_idx_t'(WORDS_PER_BLOCK - 1);

        // Bits kept when a packed block shifts by one word
        localparam int KEEP_BITS = BLOCK_BITS - WORD_BITS;

endpackage

`default_nettype wire

// ==== common/aes_cmd_pkg.sv ====
`default_nettype none

package aes_cmd_pkg;

        // Opcode lives in the low byte of the command word
        localparam int OP_BITS = 8;

        typedef enum logic [OP_BITS-1:0] {
                OP_PASS    = 8'h00,
                OP_ADD_KEY = 8'h01,
                OP_SET_KEY = 8'h02
        } cmd_op_e;

        // Input frame parser
        typedef enum logic [1:0] {
                GET_CMD,
                GET_PAYLOAD,
                DISCARD
        } decode_state_e;

        // True only for the bytes listed in cmd_op_e
        function automatic logic op_is_valid(input logic [OP_BITS-1:0] code);
                logic ok;
                case (code)
                OP_PASS, OP_ADD_KEY, OP_SET_KEY: ok = 1'b1;
                default: ok = 1'b0;
                endcase
                return ok;
        endfunction

endpackage

`default_nettype wire

// ==== source/frame_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_decode
        import aes_block_pkg::*, aes_cmd_pkg::*;
(
        input  wire logic  s00_axis_aclk,
        input  wire logic  rst,

        input  wire word_t s00_axis_tdata,
        input  wire logic  s00_axis_tvalid,
        input  wire logic  s00_axis_tlast,
        output logic       s00_axis_tready,

        output block_t     dec_block,
        output cmd_op_e    dec_op,
        output logic       dec_last,
        output logic       dec_valid,
        input  wire logic  dec_ready
);

        decode_state_e state;
        cmd_op_e       op_q;
        word_idx_t     word_cnt;
        block_t        pack_q;
        block_t        next_block;
        logic          word_in;
        logic          payload_in;
        logic          block_done;

        // Stall only while a finished block waits on execute
        assign s00_axis_tready = !(dec_valid && !dec_ready);
        assign word_in         = s00_axis_tvalid && s00_axis_tready;
        assign payload_in      = word_in && (state == GET_PAYLOAD);
        assign block_done      = payload_in && (word_cnt == LAST_WORD_IDX);

        // Newest word goes to the bottom, so word 0 ends up on top
        assign next_block = {pack_q[KEEP_BITS-1:0], s00_axis_tdata};

        // ========================================================================
        // Frame parser
        // ========================================================================

        always_ff @(posedge s00_axis_aclk) begin
                if (rst) begin
                        state     <= GET_CMD;
                        op_q      <= OP_PASS;
                        word_cnt  <= '0;
                        dec_valid <= 1'b0;
                end else begin
                        if (dec_valid && dec_ready) begin
                                dec_valid <= 1'b0;
                        end
                        if (block_done) begin
                                dec_valid <= 1'b1;
                        end

                        case (state)
                        GET_CMD: begin
                                // Command with tlast is an empty frame
                                if (word_in && !s00_axis_tlast) begin
                                        word_cnt <= '0;
                                        if (op_is_valid(s00_axis_tdata[OP_BITS-1:0])) begin
                                                op_q  <= cmd_op_e'(s00_axis_tdata[OP_BITS-1:0]);
                                                state <= GET_PAYLOAD;
                                        end else begin
                                                state <= DISCARD;
                                        end
                                end
                        end
                        GET_PAYLOAD: begin
                                if (payload_in) begin
                                        word_cnt <= word_cnt + 1'b1;
                                        // Early tlast drops the partial block
                                        if (s00_axis_tlast) begin
                                                state <= GET_CMD;
                                        end else if (block_done && op_q == OP_SET_KEY) begin
                                                state <= DISCARD;
                                        end
                                end
                        end
                        DISCARD: begin
                                if (word_in && s00_axis_tlast) begin
                                        state <= GET_CMD;
                                end
                        end
                        default: state <= GET_CMD;
                        endcase
                end
        end

        // Packing and the presented block
        always_ff @(posedge s00_axis_aclk) begin
                if (payload_in) begin
                        pack_q <= next_block;
                end
                if (block_done) begin
                        dec_block <= next_block;
                        dec_op    <= op_q;
                        dec_last  <= s00_axis_tlast;
                end
        end

        // ========================================================================
        // Checks
        // ========================================================================

        // Input frames end only on a block boundary
        assert property (@(posedge s00_axis_aclk) disable iff (rst)
                (payload_in && s00_axis_tlast) |-> (word_cnt == LAST_WORD_IDX))
        else $error("frame_decode: tlast on payload word %0d of a block", word_cnt);

        // Offered block is held until execute takes it
        assert property (@(posedge s00_axis_aclk) disable iff (rst)
                (dec_valid && !dec_ready) |=> (dec_valid && $stable(dec_block) && $stable(dec_op)))
        else $error("frame_decode: block changed or dropped before dec_ready");

endmodule

`default_nettype wire

// ==== source/key_mix_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_mix_execute
        import aes_block_pkg::*, aes_cmd_pkg::*;
(
        input  wire logic    s00_axis_aclk,
        input  wire logic    rst,

        input  wire block_t  dec_block,
        input  wire cmd_op_e dec_op,
        input  wire logic    dec_last,
        input  wire logic    dec_valid,
        output logic         dec_ready,

        output block_t       res_block,
        output logic         res_last,
        output logic         res_valid,
        input  wire logic    res_ready
);

        // Round key is zero until the first SET_KEY
        block_t key_q;
        logic   take;

        // Free to accept unless the output register is stuck
        assign dec_ready = !(res_valid && !res_ready);
        assign take      = dec_valid && dec_ready;

        always_ff @(posedge s00_axis_aclk) begin
                if (rst) begin
                        key_q     <= '0;
                        res_valid <= 1'b0;
                end else begin
                        if (res_valid && res_ready) begin
                                res_valid <= 1'b0;
                        end
                        if (take) begin
                                case (dec_op)
                                OP_SET_KEY: key_q <= dec_block;
                                OP_ADD_KEY: res_valid <= 1'b1;
                                OP_PASS:    res_valid <= 1'b1;
                                default:    res_valid <= 1'b0;
                                endcase
                        end
                end
        end

        // ========================================================================
        // AddRoundKey stage
        // ========================================================================

        always_ff @(posedge s00_axis_aclk) begin
                if (take && dec_op != OP_SET_KEY) begin
                        res_last <= dec_last;
                        case (dec_op)
                        OP_ADD_KEY: res_block <= dec_block ^ key_q;
                        default:    res_block <= dec_block;
                        endcase
                end
        end

        // Result and its data hold while the FIFO is full
        assert property (@(posedge s00_axis_aclk) disable iff (rst)
                (res_valid && !res_ready)
                        |=> (res_valid && $stable(res_block) && $stable(res_last)))
        else $error("key_mix_execute: result dropped or changed before res_ready");

endmodule

`default_nettype wire

// ==== source/result_stream.sv ====
`timescale 1ns/10ps
`default_nettype none

module result_stream
        import aes_block_pkg::*;
#(
        // Power of two of 2 or more
        parameter int OUT_FIFO_DEPTH = 4
)
(
        input  wire logic   s00_axis_aclk,
        input  wire logic   rst,

        input  wire block_t res_block,
        input  wire logic   res_last,
        input  wire logic   res_valid,
        output logic        res_ready,

        output word_t       m00_axis_tdata,
        output logic        m00_axis_tvalid,
        output logic        m00_axis_tlast,
        input  wire logic   m00_axis_tready
);

        localparam int PTR_BITS = $clog2(OUT_FIFO_DEPTH);

        // ========================================================================
        // Block FIFO
        // ========================================================================

        block_t              fifo_block [0:OUT_FIFO_DEPTH-1];
        logic                fifo_last  [0:OUT_FIFO_DEPTH-1];
        logic [PTR_BITS-1:0] wr_ptr;
        logic [PTR_BITS-1:0] rd_ptr;
        logic [PTR_BITS:0]   count;
        logic                full;
        logic                empty;
        logic                wr;
        logic                rd;

        // Unpacker
        block_t              out_block;
        logic                out_last;
        word_idx_t           word_idx;
        logic                word_done;
        logic                block_sent;

        assign full  = (count == (PTR_BITS+1)'(OUT_FIFO_DEPTH));
        assign empty = (count == '0);

        assign res_ready = !full;
        assign wr        = res_valid && res_ready;

        assign word_done  = m00_axis_tvalid && m00_axis_tready;
        assign block_sent = word_done && (word_idx == LAST_WORD_IDX);

        // Pull the next block when idle or on the last word of the current one
        assign rd = !empty && (!m00_axis_tvalid || block_sent);

        // Top word of the shift register is always the one on the bus
        assign m00_axis_tdata = out_block[BLOCK_BITS-1 -: WORD_BITS];
        assign m00_axis_tlast = out_last && (word_idx == LAST_WORD_IDX);

        always_ff @(posedge s00_axis_aclk) begin
                if (rst) begin
                        wr_ptr          <= '0;
                        rd_ptr          <= '0;
                        count           <= '0;
                        m00_axis_tvalid <= 1'b0;
                        word_idx        <= '0;
                end else begin
                        if (wr) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (rd) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        count <= count + (PTR_BITS+1)'(wr) - (PTR_BITS+1)'(rd);

                        if (rd) begin
                                m00_axis_tvalid <= 1'b1;
                                word_idx        <= '0;
                        end else if (word_done) begin
                                word_idx <= word_idx + 1'b1;
                                if (block_sent) begin
                                        m00_axis_tvalid <= 1'b0;
                                end
                        end
                end
        end

        always_ff @(posedge s00_axis_aclk) begin
                if (wr) begin
                        fifo_block[wr_ptr] <= res_block;
                        fifo_last[wr_ptr]  <= res_last;
                end
                if (rd) begin
                        out_block <= fifo_block[rd_ptr];
                        out_last  <= fifo_last[rd_ptr];
                end else if (word_done) begin
                        out_block <= out_block << WORD_BITS;
                end
        end

        // Slot under the write pointer must not hold an unread block
        assert property (@(posedge s00_axis_aclk) disable iff (rst)
                wr |-> !((wr_ptr == rd_ptr) && !empty))
        else $error("result_stream: block written into a full FIFO");

endmodule

`default_nettype wire

// ==== source/aes_stream_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_stream_top
        import aes_block_pkg::*, aes_cmd_pkg::*;
#(
        // Blocks buffered ahead of the word unpacker
        parameter int OUT_FIFO_DEPTH = 4
)
(
        input  wire logic  s00_axis_aclk,
        input  wire logic  rst,

        input  wire word_t s00_axis_tdata,
        input  wire logic  s00_axis_tvalid,
        input  wire logic  s00_axis_tlast,
        output logic       s00_axis_tready,

        output word_t      m00_axis_tdata,
        output logic       m00_axis_tvalid,
        output logic       m00_axis_tlast,
        input  wire logic  m00_axis_tready
);

        // Decode to execute
        block_t  dec_block;
        cmd_op_e dec_op;
        logic    dec_last;
        logic    dec_valid;
        logic    dec_ready;

        // Execute to result
        block_t  res_block;
        logic    res_last;
        logic    res_valid;
        logic    res_ready;

        frame_decode u_decode (
                .s00_axis_aclk   (s00_axis_aclk),
                .rst             (rst),
                .s00_axis_tdata  (s00_axis_tdata),
                .s00_axis_tvalid (s00_axis_tvalid),
                .s00_axis_tlast  (s00_axis_tlast),
                .s00_axis_tready (s00_axis_tready),
                .dec_block       (dec_block),
                .dec_op          (dec_op),
                .dec_last        (dec_last),
                .dec_valid       (dec_valid),
                .dec_ready       (dec_ready)
        );

        key_mix_execute u_execute (
                .s00_axis_aclk (s00_axis_aclk),
                .rst           (rst),
                .dec_block     (dec_block),
                .dec_op        (dec_op),
                .dec_last      (dec_last),
                .dec_valid     (dec_valid),
                .dec_ready     (dec_ready),
                .res_block     (res_block),
                .res_last      (res_last),
                .res_valid     (res_valid),
                .res_ready     (res_ready)
        );

        result_stream #(
                .OUT_FIFO_DEPTH (OUT_FIFO_DEPTH)
        ) u_result (
                .s00_axis_aclk   (s00_axis_aclk),
                .rst             (rst),
                .res_block       (res_block),
                .res_last        (res_last),
                .res_valid       (res_valid),
                .res_ready       (res_ready),
                .m00_axis_tdata  (m00_axis_tdata),
                .m00_axis_tvalid (m00_axis_tvalid),
                .m00_axis_tlast  (m00_axis_tlast),
                .m00_axis_tready (m00_axis_tready)
        );

endmodule

`default_nettype wire

// ==== verif/tb_aes_stream.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_aes_stream
        import aes_block_pkg::*, aes_cmd_pkg::*;
;

        logic  s00_axis_aclk   = 1'b0;
        logic  rst             = 1'b1;
        word_t s00_axis_tdata  = '0;
        logic  s00_axis_tvalid = 1'b0;
        logic  s00_axis_tlast  = 1'b0;
        logic  s00_axis_tready;
        word_t m00_axis_tdata;
        logic  m00_axis_tvalid;
        logic  m00_axis_tlast;
        logic  m00_axis_tready = 1'b0;

        // Reference model state
        block_t model_key = '0;
        word_t  exp_words [$];
        logic   exp_lasts [$];

        // Stimulus shaping in percent
        int gap_pct       = 0;
        int sink_busy_pct = 0;

        int words_sent  = 0;
        int cycle_cnt   = 0;
        int data_errors = 0;
        int last_errors = 0;
        int flag_errors = 0;
        int seq_errors  = 0;

        aes_stream_top #(
                .OUT_FIFO_DEPTH (4)
        ) UUT (
                .s00_axis_aclk   (s00_axis_aclk),
                .rst             (rst),
                .s00_axis_tdata  (s00_axis_tdata),
                .s00_axis_tvalid (s00_axis_tvalid),
                .s00_axis_tlast  (s00_axis_tlast),
                .s00_axis_tready (s00_axis_tready),
                .m00_axis_tdata  (m00_axis_tdata),
                .m00_axis_tvalid (m00_axis_tvalid),
                .m00_axis_tlast  (m00_axis_tlast),
                .m00_axis_tready (m00_axis_tready)
        );

        initial begin
                forever #5 s00_axis_aclk = ~s00_axis_aclk;
        end

        // ========================================================================
        // Compare tasks and run end
        // ========================================================================

        task automatic compare_word(input string name, input word_t got, input word_t exp);
                if (got !== exp) begin
                        data_errors++;
                        $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
                end
        endtask

        task automatic compare_last(input logic got, input logic exp);
                if (got !== exp) begin
                        last_errors++;
                        $display("[ERROR] m00_axis_tlast got 0x%0h expected 0x%0h", got, exp);
                end
        endtask

        task automatic compare_flag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        flag_errors++;
                        $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
                end
        endtask

        task automatic finish_run(input logic timed_out);
                int total;
                total = data_errors + last_errors + flag_errors + seq_errors
                        + exp_words.size() + (timed_out ? 1 : 0);
                if (exp_words.size() != 0) begin
                        $display("%0d expected output words never arrived", exp_words.size());
                end
                $write("Errors: data %0d, tlast %0d, flags %0d, ", data_errors, last_errors,
                       flag_errors);
                $display("unexpected %0d, missing %0d, timeout %0d", seq_errors,
                         exp_words.size(), timed_out ? 1 : 0);
                if (total == 0) begin
                        $display("ALL TESTS PASSED");
                end else begin
                        $display("SOME TESTS FAILED");
                end
                $finish;
        endtask

        // ========================================================================
        // Reference model and source driver
        // ========================================================================

        // Expected output of one frame with the key kept across frames
        function automatic void model_frame(input logic [7:0] op_byte, input word_t payload[$]);
                word_t key_word;
                if (payload.size() == 0) begin
                        return;
                end
                case (op_byte)
                OP_SET_KEY: begin
                        model_key = {payload[0], payload[1], payload[2], payload[3]};
                end
                OP_ADD_KEY, OP_PASS: begin
                        for (int i = 0; i < payload.size(); i++) begin
                                key_word = model_key[BLOCK_BITS-1-WORD_BITS*(i % WORDS_PER_BLOCK)
                                                     -: WORD_BITS];
                                if (op_byte == OP_ADD_KEY) begin
                                        exp_words.push_back(payload[i] ^ key_word);
                                end else begin
                                        exp_words.push_back(payload[i]);
                                end
                                exp_lasts.push_back(i == payload.size() - 1);
                        end
                end
                default: begin
                        // Unknown opcode swallows the frame
                end
                endcase
        endfunction

        // Called on a falling edge and returns on the one after the transfer
        task automatic send_word(input word_t data, input logic last);
                logic accepted;
                while (int'($urandom % 100) < gap_pct) begin
                        s00_axis_tvalid = 1'b0;
                        @(negedge s00_axis_aclk);
                end
                s00_axis_tdata  = data;
                s00_axis_tlast  = last;
                s00_axis_tvalid = 1'b1;
                accepted = 1'b0;
                while (!accepted) begin
                        accepted = s00_axis_tready;
                        @(negedge s00_axis_aclk);
                end
                s00_axis_tvalid = 1'b0;
                s00_axis_tlast  = 1'b0;
                words_sent++;
        endtask

        task automatic send_frame(input logic [7:0] op_byte, input int nblocks);
                word_t cmd;
                word_t payload [$];
                int    nwords;
                nwords = nblocks * WORDS_PER_BLOCK;
                cmd = $urandom;
                cmd[OP_BITS-1:0] = op_byte;
                for (int i = 0; i < nwords; i++) begin
                        payload.push_back($urandom);
                end
                model_frame(op_byte, payload);
                send_word(cmd, nwords == 0);
                for (int i = 0; i < nwords; i++) begin
                        send_word(payload[i], i == nwords - 1);
                end
        endtask

        // Mostly valid opcodes and now and then a byte outside the enum
        function automatic logic [7:0] random_op();
                logic [7:0] op;
                if (($urandom % 100) < 20) begin
                        op = 8'(3 + ($urandom % 253));
                end else begin
                        case ($urandom % 3)
                        0:       op = OP_PASS;
                        1:       op = OP_ADD_KEY;
                        default: op = OP_SET_KEY;
                        endcase
                end
                return op;
        endfunction

        // ========================================================================
        // Sink and watchdog
        // ========================================================================

        always @(negedge s00_axis_aclk) begin
                m00_axis_tready = (int'($urandom % 100) >= sink_busy_pct);
                // Transfer happens on the coming rising edge
                if (m00_axis_tvalid && m00_axis_tready) begin
                        if (exp_words.size() == 0) begin
                                seq_errors++;
                                $display("Output word 0x%08h arrived when none was expected",
                                         m00_axis_tdata);
                        end else begin
                                compare_word("m00_axis_tdata", m00_axis_tdata,
                                             exp_words.pop_front());
                                compare_last(m00_axis_tlast, exp_lasts.pop_front());
                        end
                end
        end

        always @(posedge s00_axis_aclk) begin
                cycle_cnt++;
                if (cycle_cnt > 1000 + 20 * words_sent) begin
                        $display("Timeout: run stopped after %0d cycles without finishing",
                                 cycle_cnt);
                        finish_run(1'b1);
                end
        end

        // ========================================================================
        // Test sequence
        // ========================================================================

        initial begin
                void'($urandom(77));
                repeat (4) @(posedge s00_axis_aclk);
                @(negedge s00_axis_aclk);
                rst = 1'b0;

                compare_flag("m00_axis_tvalid", m00_axis_tvalid, 1'b0);
                compare_flag("s00_axis_tready", s00_axis_tready, 1'b1);

                // Directed frames without stalls
                send_frame(OP_PASS, 2);
                send_frame(OP_ADD_KEY, 1);
                send_frame(OP_SET_KEY, 2);
                send_frame(OP_ADD_KEY, 3);
                send_frame(8'h5a, 2);
                send_frame(OP_PASS, 0);
                send_frame(OP_SET_KEY, 0);
                send_frame(OP_PASS, 1);

                // Random frames with source gaps and sink back-pressure
                gap_pct       = 30;
                sink_busy_pct = 40;
                for (int f = 0; f < 60; f++) begin
                        send_frame(random_op(), int'($urandom % 6));
                end

                while (exp_words.size() != 0) begin
                        @(negedge s00_axis_aclk);
                end
                // Idle window to catch duplicated words
                repeat (50) @(negedge s00_axis_aclk);
                compare_flag("m00_axis_tvalid", m00_axis_tvalid, 1'b0);
                finish_run(1'b0);
        end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/aes_block_pkg.sv
common/aes_cmd_pkg.sv
source/frame_decode.sv
source/key_mix_execute.sv
source/result_stream.sv
source/aes_stream_top.sv
verif/tb_aes_stream.sv

// ==== Makefile ====
# Verilator build and run of the AES stream testbench

VERILATOR ?= verilator
TOP       ?= tb_aes_stream
SEED      ?= 77
LOG       ?= sim.log
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP SEED LOG FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
